// File: Bender.yml
package:
  name: riscv_dpath

sources:
  - common/riscv_dpath_pkg.sv
  - rtl/riscv_fetch.sv
  - rtl/decode/riscv_regfile.sv
  - rtl/decode/riscv_decode.sv
  - rtl/execute/riscv_execute.sv
  - rtl/riscv_mem_wb.sv
  - rtl/riscv_dpath.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/riscv_dpath_tb.sv

// File: common/riscv_dpath_pkg.sv
/*
 * RISC-V datapath package
 * Widths, select encodings, ALU codes and per-stage control types
 */
package riscv_dpath_pkg;

        localparam int xlen = 32;

        typedef logic [xlen-1:0] word_t;
        typedef logic [4:0]      reg_addr_t;

        localparam word_t reset_vector = 32'h0008_0000;

        // --------------------------------------------------
        // Mux select encodings
        // --------------------------------------------------

        typedef logic [1:0] pc_sel_t;
        localparam pc_sel_t pc_plus4   = 2'd0;
        localparam pc_sel_t pc_branch  = 2'd1;
        localparam pc_sel_t pc_jump    = 2'd2;
        localparam pc_sel_t pc_jumpreg = 2'd3;

        typedef logic [1:0] op0_sel_t;
        localparam op0_sel_t op0_rs1      = 2'd0;
        localparam op0_sel_t op0_pc       = 2'd1;
        localparam op0_sel_t op0_pc_plus4 = 2'd2;
        localparam op0_sel_t op0_zero     = 2'd3;

        typedef logic [2:0] op1_sel_t;
        localparam op1_sel_t op1_rs2    = 3'd0;
        localparam op1_sel_t op1_shamt  = 3'd1;
        localparam op1_sel_t op1_imm_u  = 3'd2;
        localparam op1_sel_t op1_imm_sb = 3'd3;
        localparam op1_sel_t op1_imm_i  = 3'd4;
        localparam op1_sel_t op1_imm_s  = 3'd5;
        localparam op1_sel_t op1_zero   = 3'd6;

        // Bypass source for a source operand
        typedef logic [1:0] byp_sel_t;
        localparam byp_sel_t byp_sel_rf = 2'd0;
        localparam byp_sel_t byp_sel_x  = 2'd1;
        localparam byp_sel_t byp_sel_m  = 2'd2;
        localparam byp_sel_t byp_sel_w  = 2'd3;

        typedef logic [3:0] alu_fn_t;
        localparam alu_fn_t alu_add    = 4'd0;
        localparam alu_fn_t alu_sub    = 4'd1;
        localparam alu_fn_t alu_sll    = 4'd2;
        localparam alu_fn_t alu_or     = 4'd3;
        localparam alu_fn_t alu_lt     = 4'd4;
        localparam alu_fn_t alu_ltu    = 4'd5;
        localparam alu_fn_t alu_and    = 4'd6;
        localparam alu_fn_t alu_xor    = 4'd7;
        localparam alu_fn_t alu_nor    = 4'd8;
        localparam alu_fn_t alu_srl    = 4'd9;
        localparam alu_fn_t alu_sra    = 4'd10;
        localparam alu_fn_t alu_cp_op0 = 4'd11;
        localparam alu_fn_t alu_cp_op1 = 4'd12;

        typedef logic [2:0] load_kind_t;
        localparam load_kind_t ld_word = 3'd0;
        localparam load_kind_t ld_lb   = 3'd1;
        localparam load_kind_t ld_lbu  = 3'd2;
        localparam load_kind_t ld_lh   = 3'd3;
        localparam load_kind_t ld_lhu  = 3'd4;

        // --------------------------------------------------
        // Instruction views and stage controls
        // --------------------------------------------------

        // R and I formats, imm_i is {funct7, rs2}
        typedef struct packed {
                logic [6:0] funct7;
                reg_addr_t  rs2;
                reg_addr_t  rs1;
                logic [2:0] funct3;
                reg_addr_t  rd;
                logic [6:0] opcode;
        } r_i_fmt_t;

        typedef struct packed {
                logic [6:0] imm_hi;
                reg_addr_t  rs2;
                reg_addr_t  rs1;
                logic [2:0] funct3;
                logic [4:0] imm_lo;
                logic [6:0] opcode;
        } s_fmt_t;

        typedef union packed {
                r_i_fmt_t r_i_fmt;
                s_fmt_t   s_fmt;
        } inst_u;

        typedef struct packed {
                inst_u    inst;
                op0_sel_t op0_sel;
                op1_sel_t op1_sel;
                byp_sel_t rs1_byp;
                byp_sel_t rs2_byp;
        } ctrl_d_t;

        // wb_sel: 0 execute result, 1 load value
        typedef struct packed {
                load_kind_t load_kind;
                logic       wb_sel;
        } ctrl_m_t;

        typedef struct packed {
                logic      rf_wen;
                reg_addr_t rf_waddr;
        } ctrl_w_t;

        typedef struct packed {
                logic f;
                logic d;
                logic x;
                logic m;
                logic w;
        } stall_t;

        typedef struct packed {
                logic eq;
                logic ne;
                logic lt;
                logic ltu;
                logic ge;
                logic geu;
        } branch_cond_t;

endpackage

// File: flist.f
common/riscv_dpath_pkg.sv
rtl/riscv_fetch.sv
rtl/decode/riscv_regfile.sv
rtl/decode/riscv_decode.sv
rtl/execute/riscv_execute.sv
rtl/riscv_mem_wb.sv
rtl/riscv_dpath.sv
verification/tb_clock_gen.sv
verification/riscv_dpath_tb.sv

// File: rtl/decode/riscv_decode.sv
/*
 * Decode stage: immediates, jump targets, operand bypass and muxes
 * Holds the F-to-D and D-to-X pipeline registers
 */
`timescale 1ns/1ns

module riscv_decode
        import riscv_dpath_pkg::*;
(
        input  logic    clk,
        input  stall_t  stall,
        input  ctrl_d_t ctrl_d,
        input  word_t   pc_f,
        input  word_t   pc_plus4_f,
        input  word_t   byp_x,
        input  word_t   byp_m,
        input  word_t   byp_w,
        input  word_t   wb_data_w,
        input  ctrl_w_t wb_ctrl_w,
        output word_t   jump_targ,
        output word_t   jumpreg_targ,
        output word_t   op0_x,
        output word_t   op1_x,
        output word_t   wdata_x,
        output word_t   branch_targ_x
);

        word_t    pc_d;
        word_t    pc_plus4_d;
        r_i_fmt_t ri;
        s_fmt_t   sf;
        word_t    imm_i, imm_s, imm_sb, imm_u, imm_uj, shamt;
        word_t    rf_rdata0, rf_rdata1;
        word_t    rs1_val, rs2_val;
        word_t    jumpreg_sum;
        word_t    op0_d, op1_d;

        always_ff @(posedge clk)
        begin
                if (!stall.d)
                begin
                        pc_d       <= pc_f;
                        pc_plus4_d <= pc_plus4_f;
                end
        end

        // --------------------------------------------------
        // Immediates from both instruction views
        // --------------------------------------------------

        assign ri = ctrl_d.inst.r_i_fmt;
        assign sf = ctrl_d.inst.s_fmt;

        assign imm_i  = {{20{ri.funct7[6]}}, ri.funct7, ri.rs2};
        assign imm_s  = {{20{sf.imm_hi[6]}}, sf.imm_hi, sf.imm_lo};
        assign imm_sb = {{20{sf.imm_hi[6]}}, sf.imm_lo[0], sf.imm_hi[5:0],
                         sf.imm_lo[4:1], 1'b0};
        assign imm_u  = {ri.funct7, ri.rs2, ri.rs1, ri.funct3, 12'd0};
        assign imm_uj = {{12{ri.funct7[6]}}, ri.rs1, ri.funct3, ri.rs2[0],
                         ri.funct7[5:0], ri.rs2[4:1], 1'b0};
        assign shamt  = {27'd0, ri.rs2};

        riscv_regfile i_riscv_regfile (
                .clk    (clk),
                .raddr0 (ri.rs1),
                .raddr1 (ri.rs2),
                .wen    (wb_ctrl_w.rf_wen),
                .waddr  (wb_ctrl_w.rf_waddr),
                .wdata  (wb_data_w),
                .rdata0 (rf_rdata0),
                .rdata1 (rf_rdata1)
        );

        function automatic word_t pick_byp(byp_sel_t sel, word_t rf, word_t x,
                                           word_t m, word_t w);
                case (sel)
                        byp_sel_rf: return rf;
                        byp_sel_x:  return x;
                        byp_sel_m:  return m;
                        default:    return w;
                endcase
        endfunction

        assign rs1_val = pick_byp(ctrl_d.rs1_byp, rf_rdata0, byp_x, byp_m, byp_w);
        assign rs2_val = pick_byp(ctrl_d.rs2_byp, rf_rdata1, byp_x, byp_m, byp_w);

        // Jump targets go straight back to fetch
        assign jump_targ    = pc_d + imm_uj;
        assign jumpreg_sum  = rs1_val + imm_i;
        assign jumpreg_targ = {jumpreg_sum[31:1], 1'b0};

        always_comb
        begin
                case (ctrl_d.op0_sel)
                        op0_rs1:      op0_d = rs1_val;
                        op0_pc:       op0_d = pc_d;
                        op0_pc_plus4: op0_d = pc_plus4_d;
                        default:      op0_d = '0;
                endcase
                case (ctrl_d.op1_sel)
                        op1_rs2:    op1_d = rs2_val;
                        op1_shamt:  op1_d = shamt;
                        op1_imm_u:  op1_d = imm_u;
                        op1_imm_sb: op1_d = imm_sb;
                        op1_imm_i:  op1_d = imm_i;
                        op1_imm_s:  op1_d = imm_s;
                        default:    op1_d = '0;
                endcase
        end

        // --------------------------------------------------
        // D-to-X register
        // --------------------------------------------------

        always_ff @(posedge clk)
        begin
                if (!stall.x)
                begin
                        op0_x         <= op0_d;
                        op1_x         <= op1_d;
                        wdata_x       <= rs2_val;
                        branch_targ_x <= pc_d + imm_sb;
                end
        end

endmodule

// File: rtl/decode/riscv_regfile.sv
/*
 * Register file, 32 x 32 bits
 * Two combinational read ports, one write port, x0 reads as zero
 */
`timescale 1ns/1ns

module riscv_regfile
        import riscv_dpath_pkg::*;
(
        input  logic      clk,
        input  reg_addr_t raddr0,
        input  reg_addr_t raddr1,
        input  logic      wen,
        input  reg_addr_t waddr,
        input  word_t     wdata,
        output word_t     rdata0,
        output word_t     rdata1
);

        word_t regs [0:31];

        always_ff @(posedge clk)
        begin
                if (wen)
                begin
                        regs[waddr] <= wdata;
                end
        end

        assign rdata0 = (raddr0 == 5'd0) ? '0 : regs[raddr0];
        assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];

endmodule

// File: rtl/execute/riscv_execute.sv
/*
 * Execute stage: ALU, branch flags, data request and X-to-M register
 */
`timescale 1ns/1ns

module riscv_execute
        import riscv_dpath_pkg::*;
(
        input  logic         clk,
        input  stall_t       stall,
        input  alu_fn_t      alu_fn,
        input  word_t        op0_x,
        input  word_t        op1_x,
        input  word_t        wdata_x,
        output word_t        alu_out_x,
        output word_t        exec_result_m,
        output word_t        dmemreq_addr,
        output word_t        dmemreq_data,
        output branch_cond_t branch_cond
);

        logic diff_signs;

        always_comb
        begin
                case (alu_fn)
                        alu_add:    alu_out_x = op0_x + op1_x;
                        alu_sub:    alu_out_x = op0_x - op1_x;
                        alu_sll:    alu_out_x = op0_x << op1_x[4:0];
                        alu_or:     alu_out_x = op0_x | op1_x;
                        alu_lt:     alu_out_x = {31'd0, $signed(op0_x) < $signed(op1_x)};
                        alu_ltu:    alu_out_x = {31'd0, op0_x < op1_x};
                        alu_and:    alu_out_x = op0_x & op1_x;
                        alu_xor:    alu_out_x = op0_x ^ op1_x;
                        alu_nor:    alu_out_x = ~(op0_x | op1_x);
                        alu_srl:    alu_out_x = op0_x >> op1_x[4:0];
                        alu_sra:    alu_out_x = $signed(op0_x) >>> op1_x[4:0];
                        alu_cp_op1: alu_out_x = op1_x;
                        default:    alu_out_x = op0_x;
                endcase
        end

        // --------------------------------------------------
        // Branch flags, valid when the ALU subtracts
        // --------------------------------------------------

        // Differing signs decide the compare without the difference
        assign diff_signs = op0_x[31] ^ op1_x[31];

        assign branch_cond.eq  = (alu_out_x == '0);
        assign branch_cond.ne  = (alu_out_x != '0);
        assign branch_cond.lt  = diff_signs ? op0_x[31] : alu_out_x[31];
        assign branch_cond.ltu = diff_signs ? op1_x[31] : alu_out_x[31];
        assign branch_cond.ge  = diff_signs ? op1_x[31] : ~alu_out_x[31];
        assign branch_cond.geu = diff_signs ? op0_x[31] : ~alu_out_x[31];

        // Request leaves in X, response comes back in M
        assign dmemreq_addr = alu_out_x;
        assign dmemreq_data = wdata_x;

        always_ff @(posedge clk)
        begin
                if (!stall.m)
                begin
                        exec_result_m <= alu_out_x;
                end
        end

endmodule

// File: rtl/riscv_dpath.sv
/*
 * Five-stage RISC-V integer datapath, top level
 * Stages are steered by an external controller through per-stage controls
 */
`timescale 1ns/1ns

module riscv_dpath
        import riscv_dpath_pkg::*;
(
        input  logic         clk,
        input  logic         reset,
        input  pc_sel_t      pc_sel,
        input  ctrl_d_t      ctrl_d,
        input  alu_fn_t      alu_fn,
        input  ctrl_m_t      ctrl_m,
        input  ctrl_w_t      ctrl_w,
        input  stall_t       stall,
        input  word_t        dmemresp_data,
        output word_t        imemreq_addr,
        output word_t        dmemreq_addr,
        output word_t        dmemreq_data,
        output branch_cond_t branch_cond,
        output word_t        csr_data
);

        word_t pc_f, pc_plus4_f;
        word_t jump_targ, jumpreg_targ, branch_targ_x;
        word_t op0_x, op1_x, wdata_x;
        word_t alu_out_x, exec_result_m;
        word_t wb_data_m, wb_data_w;

        riscv_fetch i_riscv_fetch (
                .clk          (clk),
                .reset        (reset),
                .stall        (stall),
                .pc_sel       (pc_sel),
                .branch_targ  (branch_targ_x),
                .jump_targ    (jump_targ),
                .jumpreg_targ (jumpreg_targ),
                .imemreq_addr (imemreq_addr),
                .pc_f         (pc_f),
                .pc_plus4_f   (pc_plus4_f)
        );

        // Bypass taps: X ALU result, M and W writeback values
        riscv_decode i_riscv_decode (
                .clk           (clk),
                .stall         (stall),
                .ctrl_d        (ctrl_d),
                .pc_f          (pc_f),
                .pc_plus4_f    (pc_plus4_f),
                .byp_x         (alu_out_x),
                .byp_m         (wb_data_m),
                .byp_w         (wb_data_w),
                .wb_data_w     (wb_data_w),
                .wb_ctrl_w     (ctrl_w),
                .jump_targ     (jump_targ),
                .jumpreg_targ  (jumpreg_targ),
                .op0_x         (op0_x),
                .op1_x         (op1_x),
                .wdata_x       (wdata_x),
                .branch_targ_x (branch_targ_x)
        );

        riscv_execute i_riscv_execute (
                .clk           (clk),
                .stall         (stall),
                .alu_fn        (alu_fn),
                .op0_x         (op0_x),
                .op1_x         (op1_x),
                .wdata_x       (wdata_x),
                .alu_out_x     (alu_out_x),
                .exec_result_m (exec_result_m),
                .dmemreq_addr  (dmemreq_addr),
                .dmemreq_data  (dmemreq_data),
                .branch_cond   (branch_cond)
        );

        riscv_mem_wb i_riscv_mem_wb (
                .clk           (clk),
                .stall         (stall),
                .ctrl_m        (ctrl_m),
                .exec_result_m (exec_result_m),
                .dmemresp_data (dmemresp_data),
                .wb_data_m     (wb_data_m),
                .wb_data_w     (wb_data_w)
        );

        assign csr_data = wb_data_w;

endmodule

// File: rtl/riscv_fetch.sv
/*
 * Fetch stage: next-PC select, PC register and PC+4
 */
`timescale 1ns/1ns

module riscv_fetch
        import riscv_dpath_pkg::*;
(
        input  logic    clk,
        input  logic    reset,
        input  stall_t  stall,
        input  pc_sel_t pc_sel,
        input  word_t   branch_targ,
        input  word_t   jump_targ,
        input  word_t   jumpreg_targ,
        output word_t   imemreq_addr,
        output word_t   pc_f,
        output word_t   pc_plus4_f
);

        word_t pc_next;

        always_comb
        begin
                case (pc_sel)
                        pc_plus4:   pc_next = pc_plus4_f;
                        pc_branch:  pc_next = branch_targ;
                        pc_jump:    pc_next = jump_targ;
                        default:    pc_next = jumpreg_targ;
                endcase
        end

        // Request goes out in the same cycle the PC is chosen
        assign imemreq_addr = reset ? reset_vector : pc_next;

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        pc_f <= reset_vector;
                end
                else if (!stall.f)
                begin
                        pc_f <= pc_next;
                end
        end

        assign pc_plus4_f = pc_f + 32'd4;

endmodule

// File: rtl/riscv_mem_wb.sv
/*
 * Memory and writeback: load extension, writeback mux, M-to-W register
 */
`timescale 1ns/1ns

module riscv_mem_wb
        import riscv_dpath_pkg::*;
(
        input  logic    clk,
        input  stall_t  stall,
        input  ctrl_m_t ctrl_m,
        input  word_t   exec_result_m,
        input  word_t   dmemresp_data,
        output word_t   wb_data_m,
        output word_t   wb_data_w
);

        word_t load_data;

        always_comb
        begin
                case (ctrl_m.load_kind)
                        ld_lb:   load_data = {{24{dmemresp_data[7]}}, dmemresp_data[7:0]};
                        ld_lbu:  load_data = {24'd0, dmemresp_data[7:0]};
                        ld_lh:   load_data = {{16{dmemresp_data[15]}}, dmemresp_data[15:0]};
                        ld_lhu:  load_data = {16'd0, dmemresp_data[15:0]};
                        default: load_data = dmemresp_data;
                endcase
        end

        assign wb_data_m = ctrl_m.wb_sel ? load_data : exec_result_m;

        // W value feeds the register file and the CSR unit
        always_ff @(posedge clk)
        begin
                if (!stall.w)
                begin
                        wb_data_w <= wb_data_m;
                end
        end

endmodule

// File: verification/riscv_dpath_tb.sv
/*
 * Testbench for the five-stage datapath
 * Table rows are instructions with each stage's controls delayed by its distance
 */
`timescale 1ns/1ns

module riscv_dpath_tb
        import riscv_dpath_pkg::*;
();

        localparam int n_rows = 100;

        typedef struct packed {
                ctrl_d_t      ctrl_d;
                alu_fn_t      alu_fn;
                ctrl_m_t      ctrl_m;
                ctrl_w_t      ctrl_w;
                word_t        resp;
                word_t        exp_addr;
                word_t        exp_data;
                branch_cond_t exp_cond;
                word_t        exp_csr;
        } row_t;

        logic         clk, reset;
        pc_sel_t      pc_sel;
        ctrl_d_t      ctrl_d;
        alu_fn_t      alu_fn;
        ctrl_m_t      ctrl_m;
        ctrl_w_t      ctrl_w;
        stall_t       stall;
        word_t        dmemresp_data;
        word_t        imemreq_addr, dmemreq_addr, dmemreq_data, csr_data;
        branch_cond_t branch_cond;

        row_t   rows [n_rows];
        word_t  rf_model [32];
        word_t  alu_hist [n_rows];
        word_t  wb_hist [n_rows];
        int     n_fill;
        integer seed;
        word_t  exp_pc;

        tb_clock_gen i_tb_clock_gen (.clk(clk), .reset(reset));

        riscv_dpath i_riscv_dpath (
                .clk           (clk),
                .reset         (reset),
                .pc_sel        (pc_sel),
                .ctrl_d        (ctrl_d),
                .alu_fn        (alu_fn),
                .ctrl_m        (ctrl_m),
                .ctrl_w        (ctrl_w),
                .stall         (stall),
                .dmemresp_data (dmemresp_data),
                .imemreq_addr  (imemreq_addr),
                .dmemreq_addr  (dmemreq_addr),
                .dmemreq_data  (dmemreq_data),
                .branch_cond   (branch_cond),
                .csr_data      (csr_data)
        );

        // --------------------------------------------------
        // Reference model
        // --------------------------------------------------

        function automatic word_t alu_result(alu_fn_t fn, word_t a, word_t b);
                case (fn)
                        alu_add:    return a + b;
                        alu_sub:    return a - b;
                        alu_sll:    return a << b[4:0];
                        alu_or:     return a | b;
                        alu_lt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        alu_ltu:    return (a < b) ? 32'd1 : 32'd0;
                        alu_and:    return a & b;
                        alu_xor:    return a ^ b;
                        alu_nor:    return ~(a | b);
                        alu_srl:    return a >> b[4:0];
                        alu_sra:    return $signed(a) >>> b[4:0];
                        alu_cp_op1: return b;
                        default:    return a;
                endcase
        endfunction

        function automatic word_t extend_load(load_kind_t kind, word_t d);
                case (kind)
                        ld_lb:   return {{24{d[7]}}, d[7:0]};
                        ld_lbu:  return {24'd0, d[7:0]};
                        ld_lh:   return {{16{d[15]}}, d[15:0]};
                        ld_lhu:  return {16'd0, d[15:0]};
                        default: return d;
                endcase
        endfunction

        function automatic branch_cond_t compare_flags(word_t a, word_t b);
                branch_cond_t c;
                c.eq  = (a == b);
                c.ne  = (a != b);
                c.lt  = ($signed(a) < $signed(b));
                c.ltu = (a < b);
                c.ge  = ($signed(a) >= $signed(b));
                c.geu = (a >= b);
                return c;
        endfunction

        // Source value seen by row idx while it sits in D
        function automatic word_t byp_value(byp_sel_t sel, int idx, reg_addr_t addr);
                case (sel)
                        byp_sel_rf: return (addr == 5'd0) ? '0 : rf_model[addr];
                        byp_sel_x:  return alu_hist[idx-1];
                        byp_sel_m:  return wb_hist[idx-2];
                        default:    return wb_hist[idx-3];
                endcase
        endfunction

        function automatic word_t make_inst(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1);
                return {f7, rs2, rs1, 3'd0, 5'd0, 7'h13};
        endfunction

        task automatic add_row(word_t inst, op1_sel_t op1_sel, byp_sel_t rs1_byp,
                               byp_sel_t rs2_byp, alu_fn_t fn, ctrl_m_t cm, ctrl_w_t cw,
                               word_t resp);
                row_t  r;
                word_t rs1_val, rs2_val, op1_val, alu_val;
                int    i;

                i = n_fill;
                // Write of four rows back lands on the edge that starts this D
                if (i >= 4 && rows[i-4].ctrl_w.rf_wen)
                        rf_model[rows[i-4].ctrl_w.rf_waddr] = wb_hist[i-4];
                rs1_val = byp_value(rs1_byp, i, inst[19:15]);
                rs2_val = byp_value(rs2_byp, i, inst[24:20]);
                op1_val = (op1_sel == op1_imm_i) ? {{20{inst[31]}}, inst[31:20]} : rs2_val;
                alu_val = alu_result(fn, rs1_val, op1_val);
                alu_hist[i] = alu_val;
                wb_hist[i]  = cm.wb_sel ? extend_load(cm.load_kind, resp) : alu_val;

                r = '0;
                r.ctrl_d.inst    = inst;
                r.ctrl_d.op0_sel = op0_rs1;
                r.ctrl_d.op1_sel = op1_sel;
                r.ctrl_d.rs1_byp = rs1_byp;
                r.ctrl_d.rs2_byp = rs2_byp;
                r.alu_fn   = fn;
                r.ctrl_m   = cm;
                r.ctrl_w   = cw;
                r.resp     = resp;
                r.exp_addr = alu_val;
                r.exp_data = rs2_val;
                r.exp_cond = compare_flags(rs1_val, op1_val);
                r.exp_csr  = wb_hist[i];
                rows[i] = r;
                n_fill  = n_fill + 1;
        endtask

        task automatic build_table();
                word_t     rnd, resp;
                int        i, j;
                reg_addr_t ra, rb;

                // Loads fill x1..x8 with x7 and x8 on the sign boundary
                for (i = 1; i <= 8; i++)
                begin
                        rnd = $random(seed);
                        if (i == 7)
                                rnd = 32'h7fff_ffff;
                        if (i == 8)
                                rnd = 32'h8000_0000;
                        add_row('0, op1_rs2, byp_sel_rf, byp_sel_rf, alu_add,
                                {ld_word, 1'b1}, {1'b1, reg_addr_t'(i)}, rnd);
                end
                for (i = 0; i < 4; i++)
                        add_row('0, op1_rs2, byp_sel_rf, byp_sel_rf, alu_add, '0, '0, '0);

                // Every ALU code on register operands and then on immediates
                for (i = 0; i < 32; i++)
                begin
                        rnd = $random(seed);
                        ra  = reg_addr_t'(i % 8 + 1);
                        rb  = reg_addr_t'((i + 3) % 8 + 1);
                        add_row(make_inst(rnd[6:0], rb, ra), (i >= 16) ? op1_imm_i : op1_rs2,
                                byp_sel_rf, byp_sel_rf, alu_fn_t'(i % 16), '0, '0, '0);
                end

                // Subtract over x1, x6, x7, x8 in all pairings
                for (i = 0; i < 4; i++)
                begin
                        for (j = 0; j < 4; j++)
                        begin
                                ra = (i == 0) ? 5'd1 : reg_addr_t'(i + 5);
                                rb = (j == 0) ? 5'd1 : reg_addr_t'(j + 5);
                                add_row(make_inst(7'd0, rb, ra), op1_rs2, byp_sel_rf,
                                        byp_sel_rf, alu_sub, '0, '0, '0);
                        end
                end

                // Random mix of bypass, writes and loads
                for (i = 0; i < 40; i++)
                begin
                        rnd  = $random(seed);
                        resp = $random(seed);
                        add_row(make_inst(rnd[22:16], reg_addr_t'(rnd[15:12] % 9),
                                          reg_addr_t'(rnd[11:8] % 9)),
                                rnd[23] ? op1_imm_i : op1_rs2, rnd[5:4], rnd[7:6], rnd[3:0],
                                {load_kind_t'(rnd[31:29] % 5), rnd[28]},
                                {rnd[27], reg_addr_t'(rnd[26:24] + 1)}, resp);
                end
        endtask

        function automatic row_t row_at(int idx);
                if (idx < 0 || idx >= n_rows)
                        return '0;
                return rows[idx];
        endfunction

        // --------------------------------------------------
        // Compare tasks
        // --------------------------------------------------

        task automatic check_word(string name, word_t got, word_t exp);
                if (got !== exp)
                begin
                        $display("FAIL %s: got %h expected %h", name, got, exp);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "mismatch on %s", name);
                end
        endtask

        task automatic check_cond(string name, branch_cond_t got, branch_cond_t exp);
                if (got !== exp)
                begin
                        $display("FAIL %s: got %h expected %h", name, got, exp);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "mismatch on %s", name);
                end
        endtask

        initial
        begin
                int   c;
                row_t row_d, row_x, row_m, row_w;

                pc_sel        = pc_plus4;
                ctrl_d        = '0;
                alu_fn        = alu_add;
                ctrl_m        = '0;
                ctrl_w        = '0;
                stall         = '0;
                dmemresp_data = '0;
                seed          = 6324;
                n_fill        = 0;
                build_table();

                @(posedge clk);
                @(negedge clk);
                check_word("imemreq_addr", imemreq_addr, reset_vector);
                @(negedge reset);
                #1;
                check_word("imemreq_addr", imemreq_addr, reset_vector + 32'd4);
                exp_pc = reset_vector + 32'd8;

                for (c = 0; c < n_rows + 4; c++)
                begin
                        row_d = row_at(c);
                        row_x = row_at(c - 1);
                        row_m = row_at(c - 2);
                        row_w = row_at(c - 3);
                        @(posedge clk);
                        ctrl_d        <= row_d.ctrl_d;
                        alu_fn        <= row_x.alu_fn;
                        ctrl_m        <= row_m.ctrl_m;
                        dmemresp_data <= row_m.resp;
                        ctrl_w        <= row_w.ctrl_w;

                        @(negedge clk);
                        check_word("imemreq_addr", imemreq_addr, exp_pc);
                        exp_pc = exp_pc + 32'd4;
                        if (c >= 1 && c <= n_rows)
                        begin
                                check_word("dmemreq_addr", dmemreq_addr, rows[c-1].exp_addr);
                                check_word("dmemreq_data", dmemreq_data, rows[c-1].exp_data);
                                if (rows[c-1].alu_fn == alu_sub)
                                        check_cond("branch_cond", branch_cond,
                                                   rows[c-1].exp_cond);
                        end
                        if (c >= 3 && c < n_rows + 3)
                                check_word("csr_data", csr_data, rows[c-3].exp_csr);
                end

                $display("TESTBENCH PASSED");
                $finish;
        end

        // Watchdog sized from the table length plus reset and drain
        initial
        begin
                #((n_rows + 20) * 4);
                $display("Timeout: the run did not end within %0d ns", (n_rows + 20) * 4);
                $display("TESTBENCH FAILED");
                $fatal(1, "watchdog expired");
        end

endmodule

// File: verification/tb_clock_gen.sv
/*
 * Testbench clock and reset, 4 ns period, reset high for 5 cycles
 */
`timescale 1ns/1ns

module tb_clock_gen (
        output logic clk,
        output logic reset
);

        initial
        begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        initial
        begin
                reset = 1'b1;
                repeat (5) @(posedge clk);
                reset <= 1'b0;
        end

endmodule
